//--- hw/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// core side widths
`define CORE_ADDR_W 32
`define MEM_DATA_W 32

// word address toward external memory, byte address bits 25:2
`define MEM_ADDR_W 24

// cache geometry, 2**index lines of one word each
`define CACHE_INDEX_W 4
`define CACHE_TAG_W (`MEM_ADDR_W - `CACHE_INDEX_W)
`define CORE_HI_W (`CORE_ADDR_W - `MEM_ADDR_W - 2)

// which cache owns the path to memory
`define MEM_ACCESS_CACHE0 1'b0
`define MEM_ACCESS_CACHE1 1'b1
`define MEM_ACCESS_RST `MEM_ACCESS_CACHE1

`endif

//--- hw/mem_pkg.sv
`default_nettype none

`include "mem_consts.svh"

package mem_pkg;

	typedef logic [`MEM_DATA_W-1:0] mem_word_t;

	// one core byte address, read whole or split up for the cache
	typedef union packed {
		logic [`CORE_ADDR_W-1:0] raw;
		struct packed {
			logic [`CORE_HI_W-1:0] hi; // above the memory range, ignored
			logic [`CACHE_TAG_W-1:0] tag;
			logic [`CACHE_INDEX_W-1:0] index;
			logic [1:0] offset; // byte within the word
		} fields;
	} core_addr_u;

	// core -> cache
	typedef struct packed {
		logic req;
		logic rw; // 1 = write
		core_addr_u addr;
		mem_word_t wdata;
	} core_req_t;

	// cache -> controller -> buffer -> memory port
	typedef struct packed {
		logic req;
		logic rw;
		logic [`MEM_ADDR_W-1:0] addr; // word address
		mem_word_t wdata;
	} mem_req_t;

	// buffer -> controller -> cache
	typedef struct packed {
		logic done;
		mem_word_t rdata;
	} mem_rsp_t;

	// declared high to low so core 0 half-word flag lands in bit 0
	typedef struct packed {
		logic c1_word;
		logic c1_half;
		logic c0_word;
		logic c0_half;
	} exc_t;

endpackage

`default_nettype wire

//--- hw/l1_cache.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_consts.svh"

module l1_cache (
	input wire clock_i,
	input wire rst_n_i,
	input wire mem_pkg::core_req_t core_i,
	input wire uc_en_i,
	input wire mem_pkg::mem_rsp_t mem_rsp_i,
	output mem_pkg::mem_word_t core_rdata_o,
	output logic core_done_o,
	output mem_pkg::mem_req_t mem_req_o,
	output logic hit_o
);

	localparam int LINES = 1 << `CACHE_INDEX_W;

	typedef enum logic [1:0] {
		C_IDLE,
		C_WAIT, // read miss or write out at memory
		C_RESP  // done given, waiting for the core to drop req
	} cache_state_e;

	cache_state_e state_q;
	logic done_q;
	mem_pkg::mem_word_t rdata_q;

	// line storage
	logic [LINES-1:0] valid_q;
	logic [`CACHE_TAG_W-1:0] tag_q [LINES];
	mem_pkg::mem_word_t data_q [LINES];

	logic [`CACHE_INDEX_W-1:0] idx;
	logic line_hit;
	logic accept;
	logic rd_hit;
	logic mem_done;
	logic fill;
	logic wr_upd;

	// lookup
	// ------------------------------
	assign idx = core_i.addr.fields.index;
	assign line_hit = valid_q[idx] && (tag_q[idx] == core_i.addr.fields.tag);

	// new work is only taken while the controller lets us run
	assign accept = (state_q == C_IDLE) && uc_en_i && core_i.req;
	assign rd_hit = accept && !core_i.rw && line_hit;

	// the response only reaches this cache while it holds the grant
	assign mem_done = (state_q == C_WAIT) && mem_rsp_i.done;
	assign fill = mem_done && !core_i.rw;
	assign wr_upd = mem_done && core_i.rw && line_hit; // write-through, no allocate

	// control state
	// ------------------------------
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			state_q <= C_IDLE;
			done_q <= 1'b0;
			valid_q <= '0;
		end else begin
			done_q <= rd_hit || mem_done; // single cycle pulse
			if (fill) begin
				valid_q[idx] <= 1'b1;
			end
			case (state_q)
				C_IDLE: begin
					if (accept) begin
						state_q <= rd_hit ? C_RESP : C_WAIT;
					end
				end
				C_WAIT: begin
					if (mem_done) begin
						state_q <= C_RESP;
					end
				end
				C_RESP: begin
					// nothing here touches memory, so a stall does not hold it
					if (!core_i.req) begin
						state_q <= C_IDLE;
					end
				end
				default: state_q <= C_IDLE;
			endcase
		end
	end

	// arrays and read data
	// ------------------------------
	always_ff @(posedge clock_i) begin
		if (fill) begin
			tag_q[idx] <= core_i.addr.fields.tag;
			data_q[idx] <= mem_rsp_i.rdata;
		end else if (wr_upd) begin
			data_q[idx] <= core_i.wdata;
		end

		if (rd_hit) begin
			rdata_q <= data_q[idx];
		end else if (fill) begin
			rdata_q <= mem_rsp_i.rdata; // miss data goes straight back too
		end
	end

	assign core_done_o = done_q;
	assign core_rdata_o = rdata_q;

	// low while a miss or a write is out
	assign hit_o = (state_q != C_WAIT);

	// request held as a level until done
	assign mem_req_o = '{
		req: (state_q == C_WAIT),
		rw: core_i.rw,
		addr: {core_i.addr.fields.tag, core_i.addr.fields.index},
		wdata: core_i.wdata
	};

endmodule

`default_nettype wire

//--- hw/mem_controller_internal.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_consts.svh"

module mem_controller_internal (
	input wire clock_i,
	input wire rst_n_i,
	input wire mem_pkg::core_addr_u core0_addr_i,
	input wire mem_pkg::core_addr_u core1_addr_i,
	input wire hit0_i,
	input wire hit1_i,
	input wire mem_pkg::mem_req_t req0_i,
	input wire mem_pkg::mem_req_t req1_i,
	input wire mem_pkg::mem_rsp_t buf_rsp_i,
	input wire buf_busy_i,
	output mem_pkg::exc_t exceptions_o,
	output logic en0_o,
	output logic en1_o,
	output mem_pkg::mem_rsp_t rsp0_o,
	output mem_pkg::mem_rsp_t rsp1_o,
	output mem_pkg::mem_req_t buf_req_o
);

	logic choice_comb; // who would get memory this cycle
	logic choice_q;    // owner of the transfer in flight
	logic access;

	// alignment exceptions
	// ------------------------------
	assign exceptions_o = '{
		c1_word: (core1_addr_i.raw[1:0] != 2'b00),
		c1_half: core1_addr_i.raw[0],
		c0_word: (core0_addr_i.raw[1:0] != 2'b00),
		c0_half: core0_addr_i.raw[0]
	};

	// arbitration
	// ------------------------------
	always_comb begin
		case ({hit0_i, hit1_i})
			2'b00: begin
				choice_comb = `MEM_ACCESS_CACHE1; // both miss, cache 1 first
				en0_o = 1'b1;
				en1_o = 1'b0;
			end
			2'b01: begin
				choice_comb = `MEM_ACCESS_CACHE0;
				en0_o = 1'b1;
				en1_o = 1'b0;
			end
			2'b10: begin
				choice_comb = `MEM_ACCESS_CACHE1;
				en0_o = 1'b0;
				en1_o = 1'b1;
			end
			default: begin
				choice_comb = `MEM_ACCESS_CACHE1; // idle
				en0_o = 1'b1;
				en1_o = 1'b1;
			end
		endcase
	end

	// follow the table while idle, freeze once the buffer has taken a request
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			choice_q <= `MEM_ACCESS_RST;
		end else if (!buf_busy_i) begin
			choice_q <= choice_comb;
		end
	end

	assign access = buf_busy_i ? choice_q : choice_comb;

	// request and response steering
	// ------------------------------
	assign buf_req_o = (access == `MEM_ACCESS_CACHE0) ? req0_i : req1_i;

	assign rsp0_o = (access == `MEM_ACCESS_CACHE0) ? buf_rsp_i : '0;
	assign rsp1_o = (access == `MEM_ACCESS_CACHE1) ? buf_rsp_i : '0;

endmodule

`default_nettype wire

//--- hw/txrx_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_consts.svh"

module txrx_buffer (
	input wire clock_i,
	input wire rst_n_i,
	input wire mem_pkg::mem_req_t req_i,
	input wire mem_done_i,
	input wire mem_pkg::mem_word_t mem_rdata_i,
	output logic busy_o,
	output mem_pkg::mem_rsp_t rsp_o,
	output mem_pkg::mem_req_t mem_req_o
);

	typedef enum logic [1:0] {
		B_IDLE,
		B_MEM,  // request out on the memory port
		B_RSP,  // done toward the controller
		B_DROP  // wait for the requester to let go
	} buf_state_e;

	buf_state_e state_q;

	// latched request, one entry
	logic rw_q;
	logic [`MEM_ADDR_W-1:0] addr_q;
	mem_pkg::mem_word_t wdata_q;
	mem_pkg::mem_word_t rdata_q;

	logic take;
	logic mem_fin;

	assign take = (state_q == B_IDLE) && req_i.req;
	assign mem_fin = (state_q == B_MEM) && mem_done_i;

	// ------------------------------
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			state_q <= B_IDLE;
		end else begin
			case (state_q)
				B_IDLE: begin
					if (take) begin
						state_q <= B_MEM;
					end
				end
				B_MEM: begin
					if (mem_fin) begin
						state_q <= B_RSP;
					end
				end
				B_RSP: state_q <= B_DROP;
				B_DROP: begin
					if (!req_i.req) begin
						state_q <= B_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock_i) begin
		if (take) begin
			rw_q <= req_i.rw;
			addr_q <= req_i.addr;
			wdata_q <= req_i.wdata;
		end
		if (mem_fin) begin
			rdata_q <= mem_rdata_i; // don't care on writes
		end
	end

	// ------------------------------
	assign busy_o = (state_q != B_IDLE);

	assign rsp_o = '{done: (state_q == B_RSP), rdata: rdata_q};

	assign mem_req_o = '{
		req: (state_q == B_MEM),
		rw: rw_q,
		addr: addr_q,
		wdata: wdata_q
	};

endmodule

`default_nettype wire

//--- hw/mem_subsystem_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem_top (
	input wire clock_i,
	input wire rst_n_i,
	input wire mem_pkg::core_req_t core0_i,
	input wire mem_pkg::core_req_t core1_i,
	input wire mem_done_i,
	input wire mem_pkg::mem_word_t mem_rdata_i,
	output mem_pkg::mem_word_t core0_rdata_o,
	output logic core0_done_o,
	output mem_pkg::mem_word_t core1_rdata_o,
	output logic core1_done_o,
	output mem_pkg::exc_t exceptions_o,
	output mem_pkg::mem_req_t mem_req_o
);

	mem_pkg::mem_req_t c0_req;
	mem_pkg::mem_req_t c1_req;
	mem_pkg::mem_req_t buf_req;
	mem_pkg::mem_rsp_t c0_rsp;
	mem_pkg::mem_rsp_t c1_rsp;
	mem_pkg::mem_rsp_t buf_rsp;
	logic hit0;
	logic hit1;
	logic en0;
	logic en1;
	logic buf_busy;

	// caches
	// ------------------------------
	l1_cache i_cache0 (
		.clock_i(clock_i), .rst_n_i(rst_n_i),
		.core_i(core0_i), .uc_en_i(en0), .mem_rsp_i(c0_rsp),
		.core_rdata_o(core0_rdata_o), .core_done_o(core0_done_o),
		.mem_req_o(c0_req), .hit_o(hit0)
	);

	l1_cache i_cache1 (
		.clock_i(clock_i), .rst_n_i(rst_n_i),
		.core_i(core1_i), .uc_en_i(en1), .mem_rsp_i(c1_rsp),
		.core_rdata_o(core1_rdata_o), .core_done_o(core1_done_o),
		.mem_req_o(c1_req), .hit_o(hit1)
	);

	// arbitration and the path out
	// ------------------------------
	mem_controller_internal i_ctrl (
		.clock_i(clock_i), .rst_n_i(rst_n_i),
		.core0_addr_i(core0_i.addr), .core1_addr_i(core1_i.addr),
		.hit0_i(hit0), .hit1_i(hit1),
		.req0_i(c0_req), .req1_i(c1_req),
		.buf_rsp_i(buf_rsp), .buf_busy_i(buf_busy),
		.exceptions_o(exceptions_o),
		.en0_o(en0), .en1_o(en1),
		.rsp0_o(c0_rsp), .rsp1_o(c1_rsp),
		.buf_req_o(buf_req)
	);

	txrx_buffer i_buf (
		.clock_i(clock_i), .rst_n_i(rst_n_i),
		.req_i(buf_req), .mem_done_i(mem_done_i), .mem_rdata_i(mem_rdata_i),
		.busy_o(buf_busy), .rsp_o(buf_rsp), .mem_req_o(mem_req_o)
	);

endmodule

`default_nettype wire

//--- testbench/tb_mem_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_consts.svh"

module tb_mem_subsystem;

	localparam int LINES = 1 << `CACHE_INDEX_W;
	localparam int DONE_TIMEOUT = 100; // cycles per done wait
	localparam logic [31:0] SEED = 32'h6438b799;

	logic clock;
	logic rst_n;
	mem_pkg::core_req_t [1:0] core_req;
	logic mem_done;
	mem_pkg::mem_word_t mem_rdata;
	mem_pkg::mem_word_t [1:0] core_rdata;
	logic [1:0] core_done;
	mem_pkg::exc_t exc;
	mem_pkg::mem_req_t mem_req;

	// external memory, its shadow and one model per cache
	mem_pkg::mem_word_t ext_mem [256];
	mem_pkg::mem_word_t shadow_mem [256];
	logic model_valid [2][LINES];
	logic [`CACHE_TAG_W-1:0] model_tag [2][LINES];
	mem_pkg::mem_word_t model_data [2][LINES];
	mem_pkg::mem_word_t rd_result [2];
	int done_cycles [2]; // cycles from request to done
	logic [31:0] stim_state;

	mem_subsystem_top i_dut (
		.clock_i(clock), .rst_n_i(rst_n),
		.core0_i(core_req[0]), .core1_i(core_req[1]),
		.mem_done_i(mem_done), .mem_rdata_i(mem_rdata),
		.core0_rdata_o(core_rdata[0]), .core0_done_o(core_done[0]),
		.core1_rdata_o(core_rdata[1]), .core1_done_o(core_done[1]),
		.exceptions_o(exc), .mem_req_o(mem_req)
	);

	initial clock = 1'b0;
	always #50 clock = ~clock;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic mem_pkg::mem_word_t fill_word(input logic [7:0] a);
		return {~a, a ^ 8'h5a, a, a ^ 8'hc3};
	endfunction

	// reference
	// ------------------------------
	function automatic mem_pkg::mem_word_t expected_word(input logic c,
			input logic [31:0] addr);
		logic [`MEM_ADDR_W-1:0] w;
		logic [`CACHE_INDEX_W-1:0] ix;
		w = addr[25:2];
		ix = w[`CACHE_INDEX_W-1:0];
		if (model_valid[c][ix] && model_tag[c][ix] == w[`MEM_ADDR_W-1:`CACHE_INDEX_W]) begin
			return model_data[c][ix]; // own cache wins without snooping
		end
		return shadow_mem[w[7:0]];
	endfunction

	task automatic update_model(input logic c, input logic rw, input logic [31:0] addr,
			input mem_pkg::mem_word_t wdata);
		logic [`MEM_ADDR_W-1:0] w;
		logic [`CACHE_INDEX_W-1:0] ix;
		logic hit;
		w = addr[25:2];
		ix = w[`CACHE_INDEX_W-1:0];
		hit = model_valid[c][ix] && model_tag[c][ix] == w[`MEM_ADDR_W-1:`CACHE_INDEX_W];
		if (rw) begin
			shadow_mem[w[7:0]] = wdata;
			if (hit) begin
				model_data[c][ix] = wdata; // write-through without allocate
			end
		end else if (!hit) begin
			model_valid[c][ix] = 1'b1;
			model_tag[c][ix] = w[`MEM_ADDR_W-1:`CACHE_INDEX_W];
			model_data[c][ix] = shadow_mem[w[7:0]];
		end
	endtask

	// checks
	// ------------------------------
	task automatic check_word(input string name, input mem_pkg::mem_word_t exp,
			input mem_pkg::mem_word_t act);
		if (act !== exp) begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			$display("Something failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic check_exc(input string name, input mem_pkg::exc_t exp,
			input mem_pkg::exc_t act);
		if (act !== exp) begin
			$display("FAIL %s: expected %b, actual %b", name, exp, act);
			$display("Something failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAIL %s: expected %b, actual %b", name, exp, act);
			$display("Something failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	// one request on one core held until done
	task automatic core_transfer(input logic c, input logic rw, input logic [31:0] addr,
			input mem_pkg::mem_word_t wdata);
		int n;
		core_req[c].req = 1'b1;
		core_req[c].rw = rw;
		core_req[c].addr.raw = addr;
		core_req[c].wdata = wdata;
		n = 0;
		while (core_done[c] !== 1'b1) begin
			if (n == DONE_TIMEOUT) begin
				$display("timeout: core %0d saw no done within %0d cycles", c,
					DONE_TIMEOUT);
				$display("Something failed");
				$fatal(1, "wait for done expired");
			end
			@(posedge clock);
			#10;
			n++;
		end
		done_cycles[c] = n;
		rd_result[c] = core_rdata[c];
		core_req[c].req = 1'b0;
		@(posedge clock); // req low for one cycle
		#10;
	endtask

	task automatic single_op(input logic c, input logic rw, input logic [31:0] addr,
			input mem_pkg::mem_word_t wdata, input string name);
		mem_pkg::mem_word_t exp;
		exp = expected_word(c, addr);
		update_model(c, rw, addr, wdata);
		core_transfer(c, rw, addr, wdata);
		if (!rw) begin
			check_word(name, exp, rd_result[c]);
		end
	endtask

	// both cores start together and cache 1 goes first when both need memory
	task automatic paired_ops(input logic rw0, input logic [31:0] a0,
			input mem_pkg::mem_word_t d0, input logic rw1, input logic [31:0] a1,
			input mem_pkg::mem_word_t d1, input string name);
		mem_pkg::mem_word_t exp0;
		mem_pkg::mem_word_t exp1;
		mem_pkg::exc_t exp_exc;
		exp1 = expected_word(1'b1, a1);
		update_model(1'b1, rw1, a1, d1);
		exp0 = expected_word(1'b0, a0);
		update_model(1'b0, rw0, a0, d0);
		exp_exc.c0_half = a0[0];
		exp_exc.c0_word = |a0[1:0];
		exp_exc.c1_half = a1[0];
		exp_exc.c1_word = |a1[1:0];
		fork
			core_transfer(1'b0, rw0, a0, d0);
			core_transfer(1'b1, rw1, a1, d1);
			begin
				#5;
				check_exc(name, exp_exc, exc); // requests still held here
			end
		join
		if (!rw0) begin
			check_word(name, exp0, rd_result[0]);
		end
		if (!rw1) begin
			check_word(name, exp1, rd_result[1]);
		end
	endtask

	// external memory with 1 to 6 cycles latency
	// ------------------------------
	initial begin : ext_memory
		logic [31:0] lat_state;
		int lat;
		lat_state = SEED;
		mem_done = 1'b0;
		mem_rdata = '0;
		for (int i = 0; i < 256; i++) begin
			ext_mem[i] = fill_word(i[7:0]);
		end
		forever begin
			@(posedge clock);
			#10;
			if (mem_req.req) begin
				lat_state = xorshift(lat_state);
				lat = int'(lat_state % 32'd6) + 1;
				repeat (lat - 1) begin
					@(posedge clock);
					#10;
				end
				if (mem_req.rw) begin
					ext_mem[mem_req.addr[7:0]] = mem_req.wdata;
				end else begin
					mem_rdata = ext_mem[mem_req.addr[7:0]];
				end
				mem_done = 1'b1;
				@(posedge clock);
				#10;
				mem_done = 1'b0;
			end
		end
	end

	initial begin
		logic [31:0] a0;
		logic [31:0] a1;
		logic rw0;
		logic rw1;
		mem_pkg::mem_word_t d0;
		mem_pkg::mem_word_t d1;
		core_req = '0;
		rst_n = 1'b0;
		stim_state = SEED;
		for (int i = 0; i < 256; i++) begin
			shadow_mem[i] = fill_word(i[7:0]);
		end
		for (int i = 0; i < LINES; i++) begin
			model_valid[0][i] = 1'b0;
			model_valid[1][i] = 1'b0;
		end
		repeat (2) @(posedge clock);
		#10;
		rst_n = 1'b1;

		repeat (5) begin // quiet after reset
			@(posedge clock);
			#10;
			check_level("idle core0 done", 1'b0, core_done[0]);
			check_level("idle core1 done", 1'b0, core_done[1]);
			check_level("idle memory req", 1'b0, mem_req.req);
		end

		single_op(1'b0, 1'b1, 32'h0000_0104, 32'h5e3a_91c7, "write");
		single_op(1'b0, 1'b0, 32'h0000_0104, '0, "read back miss");
		check_level("read back miss latency", 1'b0, done_cycles[0] == 1);
		single_op(1'b0, 1'b0, 32'h0000_0104, '0, "read back hit");
		check_level("read back hit latency", 1'b1, done_cycles[0] == 1);

		repeat (200) begin
			stim_state = xorshift(stim_state);
			a0 = {24'h0, stim_state[5:0], 2'b00};
			rw0 = stim_state[31];
			stim_state = xorshift(stim_state);
			single_op(1'b0, rw0, a0, stim_state, "core0 random");
		end

		repeat (150) begin // overlapping 32 word window
			stim_state = xorshift(stim_state);
			a0 = {25'h0, stim_state[4:0], 2'b00};
			a1 = {25'h0, stim_state[9:5], 2'b00};
			rw0 = stim_state[30];
			rw1 = stim_state[31];
			stim_state = xorshift(stim_state);
			d0 = stim_state;
			stim_state = xorshift(stim_state);
			d1 = stim_state;
			paired_ops(rw0, a0, d0, rw1, a1, d1, "dual random");
		end

		single_op(1'b0, 1'b0, 32'h0000_0040, '0, "stale fill");
		single_op(1'b1, 1'b1, 32'h0000_0040, 32'h0f1e_2d3c, "other core write");
		single_op(1'b0, 1'b0, 32'h0000_0040, '0, "stale read");
		single_op(1'b1, 1'b0, 32'h0000_0040, '0, "writer read");

		paired_ops(1'b0, 32'h0000_0021, '0, 1'b0, 32'h0000_0032, '0, "misaligned a");
		paired_ops(1'b0, 32'h0000_0012, '0, 1'b0, 32'h0000_0009, '0, "misaligned b");

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hw
hw/mem_pkg.sv
hw/l1_cache.sv
hw/mem_controller_internal.sv
hw/txrx_buffer.sv
hw/mem_subsystem_top.sv
testbench/tb_mem_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --timescale 1ns/1ns -f flist.f \
	--top-module tb_mem_subsystem -o tb_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "Something failed" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "Everything OK" sim.log || { echo "simulation did not finish, see sim.log"; exit 1; }
echo "simulation passed"
